/* vlog.f */
verilog/lc3b_isa_pkg.sv
verilog/lc3b_pipe_pkg.sv
verilog/stage_reg.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/decode_unit.sv
verilog/hazard_forward_unit.sv
verilog/execute_unit.sv
verilog/memory_unit.sv
verilog/lc3b_pipeline.sv
tests/tb_clock.sv
tests/lc3b_pipeline_tb.sv

/* tests/lc3b_pipeline_tb.sv */
`timescale 1ns/1ps

module lc3b_pipeline_tb;

    localparam int BODY_LEN = 50;
    localparam int PROG_LEN = BODY_LEN + 11;        // setup, body, register dump, halt
    localparam int DELAY_TAB = 1024;
    localparam int DRAIN_LIMIT = 6000;
    localparam int HALT_LIMIT = 200;
    localparam int QUIET_CYCLES = 50;
    localparam lc3b_isa_pkg::reg_idx_t BASE_REG = 3'd6;
    localparam lc3b_isa_pkg::word_t BASE_ADDR = 16'd14;

    logic                     clk;
    logic                     rst_n;
    lc3b_pipe_pkg::mem_resp_t imem_resp;
    lc3b_pipe_pkg::mem_resp_t dmem_resp;
    lc3b_pipe_pkg::mem_req_t  imem_req;
    lc3b_pipe_pkg::mem_req_t  dmem_req;

    lc3b_isa_pkg::word_t      prog [PROG_LEN];
    lc3b_isa_pkg::word_t      data_mem [lc3b_isa_pkg::word_t];
    lc3b_pipe_pkg::mem_req_t  exp_acc [$];        // ordered data accesses of the model
    int unsigned              delay_tab [DELAY_TAB];
    logic                     mem_on;
    lc3b_isa_pkg::word_t      halt_pc;

    tb_clock clock_i
    (
        .clk (clk)
    );

    lc3b_pipeline dut_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_resp (imem_resp),
        .dmem_resp (dmem_resp),
        .imem_req  (imem_req),
        .dmem_req  (dmem_req)
    );

    function automatic lc3b_isa_pkg::word_t sext(input lc3b_isa_pkg::word_t v, input int w);
        lc3b_isa_pkg::word_t m;
        m = 16'hFFFF << w;
        return v[w-1] ? (v | m) : (v & ~m);
    endfunction

    // initial data memory content unique per address
    function automatic lc3b_isa_pkg::word_t fill_word(input lc3b_isa_pkg::word_t addr);
        return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic lc3b_isa_pkg::nzp_t cc_of(input lc3b_isa_pkg::word_t r);
        if (r[15])
            return lc3b_isa_pkg::CC_N;
        if (r == '0)
            return lc3b_isa_pkg::CC_Z;
        return lc3b_isa_pkg::CC_P;
    endfunction

    // half the time reuse the latest dest for dependency chains
    function automatic lc3b_isa_pkg::reg_idx_t pick_src(input lc3b_isa_pkg::reg_idx_t last);
        if ($urandom % 2)
            return last;
        return 3'($urandom % 8);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_store(input lc3b_pipe_pkg::mem_req_t want,
                               input lc3b_pipe_pkg::mem_req_t got);
        if (got !== want)
            fail_run($sformatf("Error at %0t: store to %h data %h, expected %s to %h data %h",
                               $time, got.addr, got.wdata, want.write ? "store" : "load",
                               want.addr, want.wdata));
    endtask

    task automatic check_load_addr(input lc3b_isa_pkg::word_t want,
                                   input lc3b_isa_pkg::word_t got);
        if (got !== want)
            fail_run($sformatf("Error at %0t: load from %h, expected load from %h",
                               $time, got, want));
    endtask

    task automatic check_req(input lc3b_pipe_pkg::mem_req_t want,
                             input lc3b_pipe_pkg::mem_req_t got, input string port);
        if (got !== want)
            fail_run($sformatf("Error at %0t: %s request is %h, expected %h",
                               $time, port, got, want));
    endtask

    task automatic build_program();
        lc3b_isa_pkg::reg_idx_t dr;
        lc3b_isa_pkg::reg_idx_t last;
        lc3b_isa_pkg::opcode_t  op;
        lc3b_isa_pkg::word_t    w;
        int                     kind;
        last = 3'd0;
        prog[0] = {lc3b_isa_pkg::op_and, BASE_REG, BASE_REG, 1'b1, 5'b00000};
        prog[1] = {lc3b_isa_pkg::op_add, BASE_REG, BASE_REG, 1'b1, 5'(BASE_ADDR)};
        for (int i = 2; i < BODY_LEN + 2; i++)
        begin
            dr = 3'($urandom % 7);
            if (dr == BASE_REG)
                dr = 3'd7;                          // base register stays fixed
            kind = $urandom % 6;
            w = 16'($urandom);
            case (kind)
                0, 1:
                begin
                    op = (kind == 0) ? lc3b_isa_pkg::op_add : lc3b_isa_pkg::op_and;
                    if (w[0])
                        prog[i] = {op, dr, pick_src(last), 1'b1, w[5:1]};
                    else
                        prog[i] = {op, dr, pick_src(last), 3'b000, pick_src(last)};
                    last = dr;
                end
                2:
                begin
                    prog[i] = {lc3b_isa_pkg::op_not, dr, pick_src(last), 6'b111111};
                    last = dr;
                end
                3:
                begin
                    prog[i] = {lc3b_isa_pkg::op_ldr, dr, BASE_REG, 6'(w % 16)};
                    last = dr;
                end
                4:
                    prog[i] = {lc3b_isa_pkg::op_str, pick_src(last), BASE_REG, 6'(w % 16)};
                default:
                    prog[i] = {lc3b_isa_pkg::op_br, w[2:0], 9'(w[15:8] % 6)};   // forward only
            endcase
        end
        for (int r = 0; r < lc3b_isa_pkg::NUM_REGS; r++)
            prog[BODY_LEN + 2 + r] = {lc3b_isa_pkg::op_str, 3'(r), BASE_REG, 6'(16 + r)};
        prog[PROG_LEN - 1] = {lc3b_isa_pkg::op_br, 3'b111, 9'h1FF};     // branch to itself
    endtask

    // instruction set model filling exp_acc in program order
    task automatic run_model();
        lc3b_isa_pkg::word_t     regs [lc3b_isa_pkg::NUM_REGS];
        lc3b_isa_pkg::word_t     mem [lc3b_isa_pkg::word_t];
        lc3b_isa_pkg::word_t     pc;
        lc3b_isa_pkg::word_t     ir;
        lc3b_isa_pkg::word_t     b;
        lc3b_isa_pkg::word_t     r;
        lc3b_isa_pkg::word_t     addr;
        lc3b_isa_pkg::nzp_t      cc;
        lc3b_pipe_pkg::mem_req_t acc;
        pc = lc3b_isa_pkg::PC_RESET;
        cc = lc3b_isa_pkg::CC_Z;
        foreach (regs[i])
            regs[i] = '0;
        for (int n = 0; n < 4 * PROG_LEN && pc != halt_pc; n++)
        begin
            ir = prog[pc >> 1];
            pc = pc + 16'(lc3b_isa_pkg::INSTR_BYTES);
            b = ir[5] ? sext(ir, lc3b_isa_pkg::IMM5_W) : regs[ir[2:0]];
            addr = regs[ir[8:6]] + (sext(ir, lc3b_isa_pkg::OFFSET6_W) << 1);
            r = regs[ir[8:6]];
            case (ir[15:12])
                lc3b_isa_pkg::op_add: r = r + b;
                lc3b_isa_pkg::op_and: r = r & b;
                lc3b_isa_pkg::op_not: r = ~r;
                lc3b_isa_pkg::op_ldr:
                begin
                    r = mem.exists(addr) ? mem[addr] : fill_word(addr);
                    acc = '{read: 1'b1, write: 1'b0, addr: addr, wdata: '0};
                    exp_acc.push_back(acc);
                end
                lc3b_isa_pkg::op_str:
                begin
                    mem[addr] = regs[ir[11:9]];
                    acc = '{read: 1'b0, write: 1'b1, addr: addr, wdata: regs[ir[11:9]]};
                    exp_acc.push_back(acc);
                end
                default:
                begin
                    if (ir[11:9] & cc)
                        pc = pc + (sext(ir, lc3b_isa_pkg::OFFSET9_W) << 1);
                end
            endcase
            if (ir[15:12] inside {lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and,
                                  lc3b_isa_pkg::op_not, lc3b_isa_pkg::op_ldr})
            begin
                regs[ir[11:9]] = r;
                cc = cc_of(r);
            end
        end
    endtask

    // both ports answer in the same cycle
    task automatic answer_ports(input lc3b_pipe_pkg::mem_req_t ireq,
                                input lc3b_pipe_pkg::mem_req_t dreq);
        lc3b_pipe_pkg::mem_req_t want;
        imem_resp.resp = 1'b1;
        imem_resp.rdata = (ireq.addr <= halt_pc) ? prog[ireq.addr >> 1] : '0;   // nops beyond
        if (dreq.read || dreq.write)
        begin
            if (exp_acc.size() == 0)
                fail_run($sformatf("unexpected data access to address %h", dreq.addr));
            else
            begin
                want = exp_acc.pop_front();
                if (dreq.write)
                begin
                    check_store(want, dreq);
                    data_mem[dreq.addr] = dreq.wdata;
                end
                else if (!want.read)
                    fail_run($sformatf("load from %h arrived where a store to %h was due",
                                       dreq.addr, want.addr));
                else
                begin
                    check_load_addr(want.addr, dreq.addr);
                    dmem_resp.rdata = data_mem.exists(dreq.addr) ? data_mem[dreq.addr]
                                                                 : fill_word(dreq.addr);
                end
                dmem_resp.resp = 1'b1;
            end
        end
    endtask

    // memory responder driving on the falling edge
    initial
    begin
        lc3b_pipe_pkg::mem_req_t cap_i;
        lc3b_pipe_pkg::mem_req_t cap_d;
        logic                    busy;
        int unsigned             wait_cnt;
        int unsigned             delay_ptr;
        busy = 1'b0;
        wait_cnt = 0;
        delay_ptr = 0;
        forever
        begin
            @(negedge clk);
            if (mem_on && !busy)
            begin
                cap_i = imem_req;                   // new request pair after an advance
                cap_d = dmem_req;
                wait_cnt = delay_tab[delay_ptr % DELAY_TAB];
                delay_ptr++;
                busy = 1'b1;
            end
            else if (mem_on)
            begin
                check_req(cap_i, imem_req, "instruction");
                check_req(cap_d, dmem_req, "data");
            end
            imem_resp = '0;
            dmem_resp = '0;
            if (busy && wait_cnt == 0)
            begin
                answer_ports(cap_i, cap_d);
                busy = 1'b0;
            end
            else if (busy)
                wait_cnt--;
        end
    end

    initial
    begin
        lc3b_pipe_pkg::mem_req_t first_fetch;
        int                      cycles;
        rst_n = 1'b0;
        mem_on = 1'b0;
        imem_resp = '0;
        dmem_resp = '0;
        void'($urandom(92));
        halt_pc = 16'((PROG_LEN - 1) * lc3b_isa_pkg::INSTR_BYTES);
        first_fetch = '{read: 1'b1, write: 1'b0, addr: lc3b_isa_pkg::PC_RESET, wdata: '0};
        build_program();
        run_model();
        foreach (delay_tab[i])
            delay_tab[i] = $urandom % 4;            // 0 to 3 cycles

        repeat (3)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_req(first_fetch, imem_req, "instruction");
        check_req('0, dmem_req, "data");
        @(posedge clk);
        mem_on = 1'b1;

        cycles = 0;
        while (exp_acc.size() != 0 && cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (exp_acc.size() != 0)
            fail_run($sformatf("timed out with %0d data accesses still missing",
                               exp_acc.size()));

        cycles = 0;
        @(negedge clk);
        while (imem_req.addr != halt_pc && cycles < HALT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (imem_req.addr != halt_pc)
            fail_run("timed out before the fetch reached the halt loop");

        repeat (QUIET_CYCLES)
        begin
            @(negedge clk);
            if (dmem_req.read || dmem_req.write)
                fail_run($sformatf("data access to %h while halted", dmem_req.addr));
        end

        $display("test passed");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
#(
    parameter real PERIOD_NS = 100.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* verilog/lc3b_pipeline.sv */
`timescale 1ns/1ps

module lc3b_pipeline
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  lc3b_pipe_pkg::mem_resp_t imem_resp,
    input  lc3b_pipe_pkg::mem_resp_t dmem_resp,
    output lc3b_pipe_pkg::mem_req_t  imem_req,
    output lc3b_pipe_pkg::mem_req_t  dmem_req
);

    logic                     advance;
    logic                     bubble;
    logic                     redirect;
    logic                     resolve;
    logic                     resolve_taken;
    logic                     predicted_taken;
    lc3b_isa_pkg::word_t      pc;
    lc3b_isa_pkg::word_t      instr;
    lc3b_isa_pkg::word_t      pc_plus2;
    lc3b_isa_pkg::word_t      redirect_pc;
    lc3b_isa_pkg::word_t      resolve_pc;
    lc3b_isa_pkg::word_t      mem_result;
    lc3b_isa_pkg::reg_idx_t   src_a;
    lc3b_isa_pkg::reg_idx_t   src_b;
    lc3b_pipe_pkg::fwd_sel_t  fwd_a;
    lc3b_pipe_pkg::fwd_sel_t  fwd_b;
    lc3b_pipe_pkg::dec_exec_t dec;
    lc3b_pipe_pkg::dec_exec_t exec_q;
    lc3b_pipe_pkg::exec_mem_t xm;
    lc3b_pipe_pkg::exec_mem_t mem_q;
    lc3b_pipe_pkg::mem_wb_t   mw;
    lc3b_pipe_pkg::mem_wb_t   wb_q;

    assign imem_req = '{read: 1'b1, write: 1'b0, addr: pc, wdata: '0};

    // whole pipe waits on whichever port is still busy
    assign advance = imem_resp.resp
                     && (dmem_resp.resp || !(dmem_req.read || dmem_req.write));

    fetch_unit fetch_i
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .advance         (advance),
        .hold            (bubble),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .resolve         (resolve),
        .resolve_pc      (resolve_pc),
        .resolve_taken   (resolve_taken),
        .imem_resp       (imem_resp),
        .pc              (pc),
        .instr           (instr),
        .pc_plus2        (pc_plus2),
        .predicted_taken (predicted_taken)
    );

    decode_unit decode_i
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr           (instr),
        .pc_plus2        (pc_plus2),
        .predicted_taken (predicted_taken),
        .wb              (wb_q),
        .advance         (advance),
        .dec             (dec),
        .src_a           (src_a),
        .src_b           (src_b)
    );

    hazard_forward_unit hazard_i
    (
        .src_a  (src_a),
        .src_b  (src_b),
        .exec   (exec_q),
        .mem    (mem_q),
        .wb     (wb_q),
        .bubble (bubble),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    stage_reg #(.payload_t(lc3b_pipe_pkg::dec_exec_t)) exec_reg_i
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .flush   (redirect),
        .bubble  (bubble),              // load-use slot
        .d       (dec),
        .q       (exec_q)
    );

    execute_unit execute_i
    (
        .exec       (exec_q),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (mem_result),
        .wb_result  (wb_q.result),
        .xm         (xm)
    );

    stage_reg #(.payload_t(lc3b_pipe_pkg::exec_mem_t)) mem_reg_i
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .flush   (redirect),
        .bubble  (1'b0),
        .d       (xm),
        .q       (mem_q)
    );

    memory_unit memory_i
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .advance       (advance),
        .xm            (mem_q),
        .dmem_resp     (dmem_resp),
        .dmem_req      (dmem_req),
        .mw            (mw),
        .mem_result    (mem_result),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .resolve       (resolve),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken)
    );

    // resolving branch itself retires, so writeback never flushes
    stage_reg #(.payload_t(lc3b_pipe_pkg::mem_wb_t)) wb_reg_i
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .flush   (1'b0),
        .bubble  (1'b0),
        .d       (mw),
        .q       (wb_q)
    );

endmodule

/* verilog/memory_unit.sv */
`timescale 1ns/1ps

module memory_unit
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     advance,
    input  lc3b_pipe_pkg::exec_mem_t xm,
    input  lc3b_pipe_pkg::mem_resp_t dmem_resp,
    output lc3b_pipe_pkg::mem_req_t  dmem_req,
    output lc3b_pipe_pkg::mem_wb_t   mw,
    output lc3b_isa_pkg::word_t      mem_result,
    output logic                     redirect,
    output lc3b_isa_pkg::word_t      redirect_pc,
    output logic                     resolve,
    output lc3b_isa_pkg::word_t      resolve_pc,
    output logic                     resolve_taken
);

    lc3b_isa_pkg::nzp_t  cc;
    lc3b_isa_pkg::nzp_t  new_cc;
    lc3b_isa_pkg::word_t result;
    logic                taken;

    assign dmem_req = '{read: xm.ctrl.mem_read, write: xm.ctrl.mem_write,
                        addr: xm.addr, wdata: xm.store_data};

    assign result = xm.ctrl.mem_read ? dmem_resp.rdata : xm.alu_result;
    assign mw = '{ctrl: xm.ctrl, result: result, dest: xm.dest};
    assign mem_result = xm.alu_result;          // forwarding source

    always_comb
    begin
        if (result[15])
            new_cc = lc3b_isa_pkg::CC_N;
        else if (result == '0)
            new_cc = lc3b_isa_pkg::CC_Z;
        else
            new_cc = lc3b_isa_pkg::CC_P;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cc <= lc3b_isa_pkg::CC_Z;
        else if (advance && xm.ctrl.load_cc)
            cc <= new_cc;
    end

    assign taken = |(xm.nzp & cc);
    assign resolve = xm.ctrl.valid && xm.ctrl.is_branch;
    assign resolve_taken = taken;
    assign resolve_pc = xm.pc_plus2 - lc3b_isa_pkg::word_t'(lc3b_isa_pkg::INSTR_BYTES);
    assign redirect = resolve && (taken != xm.predicted_taken);
    assign redirect_pc = taken ? xm.addr : xm.pc_plus2;

    rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req.read && dmem_req.write));

    // pipeline holds the request until the port answers
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_req.read || dmem_req.write) && !dmem_resp.resp |=> $stable(dmem_req));

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
(
    input  lc3b_pipe_pkg::dec_exec_t exec,
    input  lc3b_pipe_pkg::fwd_sel_t  fwd_a,
    input  lc3b_pipe_pkg::fwd_sel_t  fwd_b,
    input  lc3b_isa_pkg::word_t      mem_result,
    input  lc3b_isa_pkg::word_t      wb_result,
    output lc3b_pipe_pkg::exec_mem_t xm
);

    lc3b_isa_pkg::word_t op_a;
    lc3b_isa_pkg::word_t op_b;
    lc3b_isa_pkg::word_t imm5;
    lc3b_isa_pkg::word_t off6;
    lc3b_isa_pkg::word_t off9;
    lc3b_isa_pkg::word_t alu_b;
    lc3b_isa_pkg::word_t alu_out;
    lc3b_isa_pkg::word_t addr_sum;

    always_comb
    begin
        case (fwd_a)
            lc3b_pipe_pkg::fwd_mem: op_a = mem_result;
            lc3b_pipe_pkg::fwd_wb:  op_a = wb_result;
            default:                op_a = exec.src_a_val;
        endcase
        case (fwd_b)
            lc3b_pipe_pkg::fwd_mem: op_b = mem_result;
            lc3b_pipe_pkg::fwd_wb:  op_b = wb_result;
            default:                op_b = exec.src_b_val;
        endcase
    end

    assign imm5 = lc3b_isa_pkg::word_t'(signed'(exec.instr[lc3b_isa_pkg::IMM5_W-1:0]));
    assign off6 = lc3b_isa_pkg::word_t'(signed'(exec.instr[lc3b_isa_pkg::OFFSET6_W-1:0])) << 1;
    assign off9 = lc3b_isa_pkg::word_t'(signed'(exec.instr[lc3b_isa_pkg::OFFSET9_W-1:0])) << 1;
    assign alu_b = exec.ctrl.alu_imm ? imm5 : op_b;

    always_comb
    begin
        case (exec.ctrl.opcode)
            lc3b_isa_pkg::op_and: alu_out = op_a & alu_b;
            lc3b_isa_pkg::op_not: alu_out = ~op_a;
            default:              alu_out = op_a + alu_b;
        endcase
    end

    // shared adder for data address and branch target
    assign addr_sum = exec.ctrl.is_branch ? exec.pc_plus2 + off9 : op_a + off6;

    assign xm = '{ctrl: exec.ctrl, alu_result: alu_out, addr: addr_sum,
                  store_data: op_b, dest: exec.dest, nzp: exec.instr[11:9],
                  pc_plus2: exec.pc_plus2, predicted_taken: exec.predicted_taken};

endmodule

/* verilog/hazard_forward_unit.sv */
`timescale 1ns/1ps

module hazard_forward_unit
(
    input  lc3b_isa_pkg::reg_idx_t   src_a,
    input  lc3b_isa_pkg::reg_idx_t   src_b,
    input  lc3b_pipe_pkg::dec_exec_t exec,
    input  lc3b_pipe_pkg::exec_mem_t mem,
    input  lc3b_pipe_pkg::mem_wb_t   wb,
    output logic                     bubble,
    output lc3b_pipe_pkg::fwd_sel_t  fwd_a,
    output lc3b_pipe_pkg::fwd_sel_t  fwd_b
);

    logic mem_hit;
    logic wb_hit;

    // load data only exists from writeback on
    assign mem_hit = mem.ctrl.load_regfile && !mem.ctrl.mem_read;
    assign wb_hit = wb.ctrl.load_regfile;

    assign bubble = exec.ctrl.valid && exec.ctrl.mem_read
                    && (exec.dest == src_a || exec.dest == src_b);

    always_comb
    begin
        fwd_a = lc3b_pipe_pkg::fwd_none;
        if (mem_hit && mem.dest == exec.src_a)
            fwd_a = lc3b_pipe_pkg::fwd_mem;     // youngest result wins
        else if (wb_hit && wb.dest == exec.src_a)
            fwd_a = lc3b_pipe_pkg::fwd_wb;

        fwd_b = lc3b_pipe_pkg::fwd_none;
        if (mem_hit && mem.dest == exec.src_b)
            fwd_b = lc3b_pipe_pkg::fwd_mem;
        else if (wb_hit && wb.dest == exec.src_b)
            fwd_b = lc3b_pipe_pkg::fwd_wb;
    end

endmodule

/* verilog/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  lc3b_isa_pkg::word_t       instr,
    input  lc3b_isa_pkg::word_t       pc_plus2,
    input  logic                      predicted_taken,
    input  lc3b_pipe_pkg::mem_wb_t    wb,
    input  logic                      advance,
    output lc3b_pipe_pkg::dec_exec_t  dec,
    output lc3b_isa_pkg::reg_idx_t    src_a,
    output lc3b_isa_pkg::reg_idx_t    src_b
);

    lc3b_isa_pkg::opcode_t opcode;
    lc3b_pipe_pkg::ctrl_t  ctrl;
    lc3b_isa_pkg::word_t   rdata_a;
    lc3b_isa_pkg::word_t   rdata_b;

    assign opcode = lc3b_isa_pkg::opcode_t'(instr[15:12]);
    assign src_a = instr[8:6];
    assign src_b = (opcode == lc3b_isa_pkg::op_str) ? instr[11:9] : instr[2:0];   // store data

    always_comb
    begin
        ctrl = '0;
        ctrl.opcode = opcode;
        ctrl.valid = (instr != '0);
        case (opcode)
            lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and:
            begin
                ctrl.alu_imm = instr[5];
                ctrl.load_regfile = ctrl.valid;
                ctrl.load_cc = ctrl.valid;
            end
            lc3b_isa_pkg::op_not:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            lc3b_isa_pkg::op_ldr:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.mem_read = 1'b1;
            end
            lc3b_isa_pkg::op_str: ctrl.mem_write = 1'b1;
            lc3b_isa_pkg::op_br:  ctrl.is_branch = 1'b1;
            default:              ctrl.valid = 1'b0;    // outside the subset
        endcase
    end

    regfile regfile_i
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (advance && wb.ctrl.load_regfile),
        .waddr   (wb.dest),
        .wdata   (wb.result),
        .raddr_a (src_a),
        .raddr_b (src_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign dec = '{ctrl: ctrl, instr: instr, pc_plus2: pc_plus2,
                   src_a_val: rdata_a, src_b_val: rdata_b,
                   src_a: src_a, src_b: src_b, dest: instr[11:9],
                   predicted_taken: predicted_taken};

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  lc3b_isa_pkg::reg_idx_t waddr,
    input  lc3b_isa_pkg::word_t    wdata,
    input  lc3b_isa_pkg::reg_idx_t raddr_a,
    input  lc3b_isa_pkg::reg_idx_t raddr_b,
    output lc3b_isa_pkg::word_t    rdata_a,
    output lc3b_isa_pkg::word_t    rdata_b
);

    lc3b_isa_pkg::word_t regs [lc3b_isa_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < lc3b_isa_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[waddr] <= wdata;
    end

    // same-cycle write is visible to decode
    assign rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     advance,
    input  logic                     hold,          // load-use bubble
    input  logic                     redirect,
    input  lc3b_isa_pkg::word_t      redirect_pc,
    input  logic                     resolve,
    input  lc3b_isa_pkg::word_t      resolve_pc,
    input  logic                     resolve_taken,
    input  lc3b_pipe_pkg::mem_resp_t imem_resp,
    output lc3b_isa_pkg::word_t      pc,
    output lc3b_isa_pkg::word_t      instr,
    output lc3b_isa_pkg::word_t      pc_plus2,
    output logic                     predicted_taken
);

    logic [1:0]                           ctr_table [lc3b_pipe_pkg::PRED_ENTRIES];
    logic [lc3b_pipe_pkg::PRED_IDX_W-1:0] fetch_idx;
    logic [lc3b_pipe_pkg::PRED_IDX_W-1:0] upd_idx;
    logic [1:0]                           upd_ctr;
    lc3b_isa_pkg::word_t                  seq_pc;
    lc3b_isa_pkg::word_t                  br_offset;
    lc3b_isa_pkg::word_t                  br_target;
    logic                                 predict;

    assign fetch_idx = pc[lc3b_pipe_pkg::PRED_IDX_W:1];
    assign upd_idx = resolve_pc[lc3b_pipe_pkg::PRED_IDX_W:1];
    assign seq_pc = pc + lc3b_isa_pkg::word_t'(lc3b_isa_pkg::INSTR_BYTES);
    assign br_offset =
        lc3b_isa_pkg::word_t'(signed'(imem_resp.rdata[lc3b_isa_pkg::OFFSET9_W-1:0])) << 1;
    assign br_target = seq_pc + br_offset;
    assign predict = (imem_resp.rdata[15:12] == lc3b_isa_pkg::op_br) && ctr_table[fetch_idx][1];

    // saturating two-bit update
    always_comb
    begin
        upd_ctr = ctr_table[upd_idx];
        if (resolve_taken && upd_ctr != 2'b11)
            upd_ctr = upd_ctr + 2'd1;
        else if (!resolve_taken && upd_ctr != 2'b00)
            upd_ctr = upd_ctr - 2'd1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < lc3b_pipe_pkg::PRED_ENTRIES; i++)
                ctr_table[i] <= lc3b_pipe_pkg::CTR_WEAK_NT;
        end
        else if (advance && resolve)
            ctr_table[upd_idx] <= upd_ctr;
    end

    // pc and the fetch-to-decode latch
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= lc3b_isa_pkg::PC_RESET;
            instr <= '0;
            pc_plus2 <= '0;
            predicted_taken <= 1'b0;
        end
        else if (advance)
        begin
            if (redirect)
            begin
                pc <= redirect_pc;
                instr <= '0;                // zero word decodes as a nop
                pc_plus2 <= '0;
                predicted_taken <= 1'b0;
            end
            else if (!hold)
            begin
                pc <= predict ? br_target : seq_pc;
                instr <= imem_resp.rdata;
                pc_plus2 <= seq_pc;
                predicted_taken <= predict;
            end
        end
    end

    pc_even: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

endmodule

/* verilog/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  logic     flush,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            q <= '0;
        else if (advance)
        begin
            if (flush || bubble)
                q <= '0;                    // all-zero payload is invalid
            else
                q <= d;
        end
    end

    // redirect from memory stage must survive a port stall
    flush_kept: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !advance |=> flush);

endmodule

/* verilog/lc3b_pipe_pkg.sv */
package lc3b_pipe_pkg;

    // control word, travels with the instruction
    typedef struct packed
    {
        logic                  valid;
        lc3b_isa_pkg::opcode_t opcode;
        logic                  alu_imm;      // second alu operand is imm5
        logic                  load_regfile;
        logic                  load_cc;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_branch;
    } ctrl_t;

    typedef struct packed
    {
        ctrl_t                  ctrl;
        lc3b_isa_pkg::word_t    instr;
        lc3b_isa_pkg::word_t    pc_plus2;
        lc3b_isa_pkg::word_t    src_a_val;
        lc3b_isa_pkg::word_t    src_b_val;
        lc3b_isa_pkg::reg_idx_t src_a;
        lc3b_isa_pkg::reg_idx_t src_b;
        lc3b_isa_pkg::reg_idx_t dest;
        logic                   predicted_taken;
    } dec_exec_t;

    typedef struct packed
    {
        ctrl_t                  ctrl;
        lc3b_isa_pkg::word_t    alu_result;
        lc3b_isa_pkg::word_t    addr;        // data address or branch target
        lc3b_isa_pkg::word_t    store_data;
        lc3b_isa_pkg::reg_idx_t dest;
        lc3b_isa_pkg::nzp_t     nzp;
        lc3b_isa_pkg::word_t    pc_plus2;
        logic                   predicted_taken;
    } exec_mem_t;

    typedef struct packed
    {
        ctrl_t                  ctrl;
        lc3b_isa_pkg::word_t    result;
        lc3b_isa_pkg::reg_idx_t dest;
    } mem_wb_t;

    typedef struct packed
    {
        logic                read;
        logic                write;
        lc3b_isa_pkg::word_t addr;
        lc3b_isa_pkg::word_t wdata;
    } mem_req_t;

    typedef struct packed
    {
        logic                resp;           // one-cycle pulse
        lc3b_isa_pkg::word_t rdata;
    } mem_resp_t;

    typedef enum logic [1:0]
    {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_t;

    localparam int PRED_ENTRIES = 32;
    localparam int PRED_IDX_W = 5;
    localparam logic [1:0] CTR_WEAK_NT = 2'b01;

endpackage

/* verilog/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [2:0]  nzp_t;            // n z p, msb first

    // opcode field [15:12], the executed subset only
    typedef enum logic [3:0]
    {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } opcode_t;

    localparam int NUM_REGS = 8;
    localparam int IMM5_W = 5;
    localparam int OFFSET6_W = 6;
    localparam int OFFSET9_W = 9;

    localparam word_t PC_RESET = 16'h0000;
    localparam int INSTR_BYTES = 2;         // pc step

    localparam nzp_t CC_N = 3'b100;
    localparam nzp_t CC_Z = 3'b010;
    localparam nzp_t CC_P = 3'b001;

endpackage
